/* design/block_ram.sv */
`include "mem_bus_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module block_ram (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire bus_pkg::bus_cmd_t cmd, // Combined bus command
	output bus_pkg::bus_rsp_t      rsp  // Broadcast response
);

	logic [`MB_DATA_W-1:0] mem [`MB_RAM_DEPTH]; // Word storage
	logic [`MB_DATA_W-1:0] rdata_q;             // Word read on the last access
	logic                  ready_q;             // Access done last cycle
	logic                  act;                 // Access happens on this edge

	// The command is still held while ready is out, skip it once
	assign act = (cmd.rd || cmd.wr) && !ready_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= act;
	end

	always_ff @(posedge clk)
	begin
		if (act && cmd.wr)
			mem[cmd.addr] <= cmd.wdata;
		if (act)
			rdata_q <= cmd.rd ? mem[cmd.addr] : '0; // Writes return zero
	end

	// Keep rdata quiet between transfers so responses can be ORed
	always_comb
	begin
		rsp.ready = ready_q;
		rsp.rdata = ready_q ? rdata_q : '0;
	end

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`include "mem_bus_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
	input  wire                      clk,
	input  wire                      rst_n,

	// Per-client request levels and grants
	input  wire client_pkg::grant_vec_t bus_req,
	output client_pkg::grant_vec_t   bus_ack,

	// Client commands, zero when not granted
	input  wire bus_pkg::bus_cmd_t   cmd_data,
	input  wire bus_pkg::bus_cmd_t   cmd_inst,

	// Combined command to the RAM and its completion strobe
	output bus_pkg::bus_cmd_t        cmd,
	input  wire                      ready
);

	import client_pkg::*;

	grant_vec_t grant_q; // One-hot owner, zero when the bus is free
	grant_vec_t pick;    // Winner among the current requests
	logic       held;    // Some client owns the bus

	// Fixed priority, the data client goes first
	always_comb
	begin
		pick = '0;
		if (bus_req[CLIENT_DATA])
			pick[CLIENT_DATA] = 1'b1;
		else if (bus_req[CLIENT_INST])
			pick[CLIENT_INST] = 1'b1;
	end

	assign held = |grant_q;

	// Grant is taken only from a free bus and kept until ready
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			grant_q <= '0;
		else if (held)
		begin
			if (ready)
				grant_q <= '0; // Owner drops bus_req on this edge too
		end
		else
			grant_q <= pick;
	end

	assign bus_ack = grant_q;

	// Ungranted clients drive zero, so OR picks out the owner
	assign cmd = cmd_data | cmd_inst;

endmodule

`default_nettype wire

/* design/bus_client_port.sv */
`include "mem_bus_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module bus_client_port (
	input  wire                   clk,
	input  wire                   rst_n,

	// Client side
	input  wire                   req,       // One-cycle request pulse
	input  wire                   rd_not_wr, // High for a read
	input  wire [`MB_ADDR_W-1:0]  addr,
	input  wire [`MB_DATA_W-1:0]  wdata,
	output logic                  busy,      // Transfer outstanding
	output logic                  done,      // Transfer finished, rdata valid
	output logic [`MB_DATA_W-1:0] rdata,

	// Bus side
	output logic                  bus_req,   // Level until served
	input  wire                   bus_ack,   // Grant from the arbiter
	output bus_pkg::bus_cmd_t     cmd,       // Zero while not granted
	input  wire bus_pkg::bus_rsp_t rsp
);

	import bus_pkg::*;

	bus_cmd_t held_cmd; // Request captured on the req pulse
	logic     pending;  // Waiting for the bus to finish
	logic     accept;   // New request taken this cycle
	logic     finish;   // Ready seen while we own the bus

	// A req pulse while a transfer is outstanding is dropped
	assign accept = req && !pending;

	// The response is broadcast, so only trust ready while granted
	assign finish = pending && bus_ack && rsp.ready;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pending <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= finish; // Pulse in the cycle after ready
			if (finish)
				pending <= 1'b0;
			else if (accept)
				pending <= 1'b1;
		end
	end

	// Holding register, loaded only when a request is accepted
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			held_cmd.addr <= addr;
			held_cmd.wdata <= wdata;
			held_cmd.rd <= rd_not_wr;
			held_cmd.wr <= !rd_not_wr;
		end
	end

	// Read word returned to the client along with done
	always_ff @(posedge clk)
	begin
		if (finish)
			rdata <= rsp.rdata;
	end

	// Drive the bus only while granted so the commands can be ORed
	always_comb
	begin
		if (pending && bus_ack)
			cmd = held_cmd;
		else
			cmd = '0;
	end

	assign busy = pending;
	assign bus_req = pending; // Same level seen from the bus side

endmodule

`default_nettype wire

/* design/bus_pkg.sv */
`include "mem_bus_macros.svh"
`default_nettype none

package bus_pkg;

	// Command from the granted client to the RAM
	// Everything is zero while no client is granted
	typedef struct packed {
		logic [`MB_ADDR_W-1:0] addr;  // Word address
		logic [`MB_DATA_W-1:0] wdata; // Write word
		logic                  rd;    // Read strobe
		logic                  wr;    // Write strobe
	} bus_cmd_t;

	// Response broadcast to every client
	typedef struct packed {
		logic [`MB_DATA_W-1:0] rdata; // Zero unless ready
		logic                  ready; // One-cycle completion strobe
	} bus_rsp_t;

endpackage

`default_nettype wire

/* design/client_pkg.sv */
`include "mem_bus_macros.svh"
`default_nettype none

package client_pkg;

	// Bus client identity, lower value wins arbitration
	typedef enum logic [0:0] {
		CLIENT_DATA = 1'b0, // Load and store traffic
		CLIENT_INST = 1'b1  // Instruction fetch, reads only
	} client_id_e;

	// One bit per client for requests and grants
	typedef logic [`MB_CLIENTS-1:0] grant_vec_t;

endpackage

`default_nettype wire

/* design/mem_bus_macros.svh */
`ifndef MEM_BUS_MACROS_SVH
`define MEM_BUS_MACROS_SVH

`default_nettype none

// Word address into the block RAM
`define MB_ADDR_W 8

// Bus data word
`define MB_DATA_W 32

// Words held by the block RAM, one per address
`define MB_RAM_DEPTH 256

// Clients sharing the bus, data and instruction fetch
`define MB_CLIENTS 2

`default_nettype wire

`endif

/* design/mem_bus_system.sv */
`include "mem_bus_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module mem_bus_system (
	input  wire                   clk,
	input  wire                   rst_n,

	// Instruction fetch client, reads only
	input  wire                   inst_req,
	input  wire [`MB_ADDR_W-1:0]  inst_addr,
	output logic                  inst_busy,
	output logic                  inst_done,
	output logic [`MB_DATA_W-1:0] inst_rdata,

	// Data client
	input  wire                   data_req,
	input  wire                   data_rd_not_wr,
	input  wire [`MB_ADDR_W-1:0]  data_addr,
	input  wire [`MB_DATA_W-1:0]  data_wdata,
	output logic                  data_busy,
	output logic                  data_done,
	output logic [`MB_DATA_W-1:0] data_rdata
);

	import bus_pkg::*;
	import client_pkg::*;

	wire grant_vec_t bus_req; // Request levels, indexed by client
	wire grant_vec_t bus_ack; // Grants, indexed by client
	wire bus_cmd_t   inst_cmd;
	wire bus_cmd_t   data_cmd;
	wire bus_cmd_t   ram_cmd; // Command after the OR combine
	wire bus_rsp_t   ram_rsp; // Seen by both ports

	bus_client_port u_inst_port (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (inst_req),
		.rd_not_wr (1'b1),                     // Fetch never writes
		.addr      (inst_addr),
		.wdata     ({`MB_DATA_W{1'b0}}),
		.busy      (inst_busy),
		.done      (inst_done),
		.rdata     (inst_rdata),
		.bus_req   (bus_req[CLIENT_INST]),
		.bus_ack   (bus_ack[CLIENT_INST]),
		.cmd       (inst_cmd),
		.rsp       (ram_rsp)
	);

	bus_client_port u_data_port (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (data_req),
		.rd_not_wr (data_rd_not_wr),
		.addr      (data_addr),
		.wdata     (data_wdata),
		.busy      (data_busy),
		.done      (data_done),
		.rdata     (data_rdata),
		.bus_req   (bus_req[CLIENT_DATA]),
		.bus_ack   (bus_ack[CLIENT_DATA]),
		.cmd       (data_cmd),
		.rsp       (ram_rsp)
	);

	bus_arbiter u_arbiter (
		.clk      (clk),
		.rst_n    (rst_n),
		.bus_req  (bus_req),
		.bus_ack  (bus_ack),
		.cmd_data (data_cmd),
		.cmd_inst (inst_cmd),
		.cmd      (ram_cmd),
		.ready    (ram_rsp.ready)
	);

	block_ram u_ram (
		.clk   (clk),
		.rst_n (rst_n),
		.cmd   (ram_cmd),
		.rsp   (ram_rsp)
	);

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/bus_pkg.sv
design/client_pkg.sv
design/bus_client_port.sv
design/bus_arbiter.sv
design/block_ram.sv
design/mem_bus_system.sv
testbench/mem_bus_chk.sv
testbench/tb_mem_bus_system.sv

/* testbench/mem_bus_chk.sv */
`include "mem_bus_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module mem_bus_chk (
	input wire                         clk,
	input wire                         rst_n,
	input wire client_pkg::grant_vec_t bus_ack,
	input wire                         ready
);

	int n_errors = 0; // Failed assertions so far

	// At most one owner at a time
	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(bus_ack))
		else
		begin
			$error("bus grant is two-hot: %b", bus_ack);
			n_errors++;
		end

	a_grant_held: assert property (@(posedge clk) disable iff (!rst_n)
		(|bus_ack && !ready) |=> bus_ack == $past(bus_ack)) // Owner keeps the bus
		else
		begin
			$error("grant changed before ready");
			n_errors++;
		end

	a_ready_granted: assert property (@(posedge clk) disable iff (!rst_n)
		ready |-> |bus_ack) // RAM answers only a granted client
		else
		begin
			$error("ready arrived with no grant");
			n_errors++;
		end

endmodule

bind bus_arbiter mem_bus_chk u_mem_bus_chk (
	.clk     (clk),
	.rst_n   (rst_n),
	.bus_ack (bus_ack),
	.ready   (ready)
);

`default_nettype wire

/* testbench/mem_bus_testdata.txt */
# name client(0 data, 1 inst) op(W write, R read, X random write, M random readback)
# then hex addr, hex wdata, hex expect, pair(0 alone, 1 next in same cycle, 2 next while busy)
wr_a10       0 W 10 cafef00d 00000000 0
rd_a10       0 R 10 00000000 cafef00d 0
wr_a20       0 W 20 12345678 00000000 0
fetch_a20    1 R 20 00000000 12345678 0
wr_a30       0 W 30 a5a5a5a5 00000000 0
wr_a31       0 W 31 5a5a5a5a 00000000 0
race_data    0 R 30 00000000 a5a5a5a5 1
race_inst    1 R 31 00000000 5a5a5a5a 0
wr_a41       0 W 41 0badf00d 00000000 0
wr_a40       0 W 40 11112222 00000000 2
busy_wr_a41  0 W 41 deadbeef 00000000 0
rd_a40       0 R 40 00000000 11112222 0
fetch_a41    1 R 41 00000000 0badf00d 0
rnd_wr_50    0 X 50 00000000 00000000 0
rnd_wr_51    0 X 51 00000000 00000000 0
rnd_wr_52    0 X 52 00000000 00000000 0
rnd_wr_53    0 X 53 00000000 00000000 0
rnd_rd_50    1 M 50 00000000 00000000 0
rnd_rd_51    0 M 51 00000000 00000000 0
rnd_rd_52    1 M 52 00000000 00000000 0
rnd_rd_53    0 M 53 00000000 00000000 0
rnd_race_52  0 M 52 00000000 00000000 1
rnd_race_53  1 M 53 00000000 00000000 0

/* testbench/tb_mem_bus_system.sv */
`include "mem_bus_macros.svh"
`timescale 1ns/10ps
`default_nettype none

module tb_mem_bus_system;

	import client_pkg::*;

	localparam int TIMEOUT = 100; // Cycles allowed for any wait
	localparam int FREE_LAT = 4;  // req to done with the bus free

	logic                  clk, rst_n;
	logic                  inst_req, inst_busy, inst_done;
	logic                  data_req, data_rd_not_wr, data_busy, data_done;
	logic [`MB_ADDR_W-1:0] inst_addr, data_addr;
	logic [`MB_DATA_W-1:0] inst_rdata, data_wdata, data_rdata;

	// Test lines with slot 1 holding the partner of a pair
	logic [8*16-1:0]       t_name [2];
	logic [7:0]            t_op [2];
	logic [`MB_ADDR_W-1:0] t_addr [2];
	logic [`MB_DATA_W-1:0] t_wdata [2], t_exp [2];
	int                    t_client [2], t_pair [2];

	logic [`MB_DATA_W-1:0] model [`MB_RAM_DEPTH]; // Last word written per address
	logic [`MB_DATA_W-1:0] got [2];               // Read word per client
	int                    done_cyc [2];          // Done cycle per client
	logic [31:0]           rng;
	logic [8*128-1:0]      header;
	int                    fd;
	int                    cycle = 0;
	int                    launch_cyc;
	int                    n_pass = 0;
	int                    n_fail = 0;
	bit                    stop = 1'b0;
	bit                    line_ok;

	mem_bus_system u_mem_bus_system (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic bit is_read(input logic [7:0] op);
		return op == "R" || op == "M";
	endfunction

	// Parses the next line of the data file into a slot
	task automatic read_line(input int slot, output bit ok);
		logic [8*16-1:0]       name;
		logic [7:0]            op;
		logic [`MB_ADDR_W-1:0] addr;
		logic [`MB_DATA_W-1:0] wdata;
		logic [`MB_DATA_W-1:0] want;
		int                    client;
		int                    pair;
		ok = ($fscanf(fd, " %s %d %s %h %h %h %d",
			name, client, op, addr, wdata, want, pair) == 7);
		if (!ok)
			return;
		if (op == "X")
		begin
			rng = xorshift32(rng);
			wdata = rng; // Fill value replaces the file column
		end
		if (op == "M")
			want = model[addr];
		t_name[slot] = name;
		t_client[slot] = client;
		t_op[slot] = op;
		t_addr[slot] = addr;
		t_wdata[slot] = wdata;
		t_exp[slot] = want;
		t_pair[slot] = pair;
	endtask

	task automatic end_test(input int slot, input bit bad);
		if (bad)
			n_fail++;
		else
			n_pass++;
		$display("%s %0s", bad ? "FAIL" : "PASS", t_name[slot]);
	endtask

	task automatic wait_idle();
		int n;
		for (n = 0; n < TIMEOUT && (data_busy || inst_busy); n++)
			@(negedge clk);
		if (data_busy || inst_busy)
		begin
			$display("Timeout: the %s client stayed busy", data_busy ? "data" : "instruction");
			n_fail++;
			stop = 1'b1;
		end
	endtask

	// want is indexed by client id
	task automatic wait_done(input logic [1:0] want);
		logic [1:0] seen;
		int         n;
		seen = ~want;
		for (n = 0; n < TIMEOUT && seen != 2'b11; n++)
		begin
			@(negedge clk);
			if (data_done && !seen[CLIENT_DATA])
				done_cyc[CLIENT_DATA] = cycle;
			if (inst_done && !seen[CLIENT_INST])
				done_cyc[CLIENT_INST] = cycle;
			seen = seen | {inst_done, data_done};
		end
		got[CLIENT_DATA] = data_rdata; // Held until the next transfer ends
		got[CLIENT_INST] = inst_rdata;
		if (seen != 2'b11)
		begin
			$display("Timeout: the %s client never finished",
				seen[CLIENT_DATA] ? "instruction" : "data");
			n_fail++;
			stop = 1'b1;
		end
	endtask

	task automatic check_slot(input int slot, input bit check_lat, input bit bad_in);
		int c;
		bit bad;
		c = t_client[slot];
		bad = bad_in;
		if (is_read(t_op[slot]) && got[c] !== t_exp[slot])
		begin
			$display("** Error %0s: expected %h, actual %h",
				t_name[slot], t_exp[slot], got[c]);
			bad = 1'b1;
		end
		if (check_lat && done_cyc[c] - launch_cyc != FREE_LAT)
		begin
			$display("** Error %0s: latency expected %0d, actual %0d",
				t_name[slot], FREE_LAT, done_cyc[c] - launch_cyc);
			bad = 1'b1;
		end
		if (!is_read(t_op[slot]))
			model[t_addr[slot]] = t_wdata[slot];
		end_test(slot, bad);
	endtask

	task automatic drive(input int slot);
		if (t_client[slot] == CLIENT_INST)
		begin
			inst_req <= 1'b1;
			inst_addr <= t_addr[slot];
		end
		else
		begin
			data_req <= 1'b1;
			data_rd_not_wr <= is_read(t_op[slot]);
			data_addr <= t_addr[slot];
			data_wdata <= t_wdata[slot];
		end
	endtask

	task automatic run_group();
		bit paired;
		bit both;
		bit bad;
		int n;
		paired = 1'b0;
		if (t_pair[0] != 0)
			read_line(1, paired);
		both = paired && t_pair[0] == 1;
		wait_idle();
		if (stop)
			return;
		@(posedge clk);
		drive(0);
		if (both)
			drive(1);
		launch_cyc = cycle + 1; // Counter value once this edge settles
		@(posedge clk);
		if (paired && !both)
		begin
			drive(1); // Lands while the port is busy
			@(posedge clk);
		end
		inst_req <= 1'b0;
		data_req <= 1'b0;
		wait_done({t_client[0] == CLIENT_INST || both, t_client[0] == CLIENT_DATA || both});
		if (stop)
			return;
		check_slot(0, !both, 1'b0);
		if (both)
		begin
			bad = done_cyc[CLIENT_DATA] >= done_cyc[CLIENT_INST];
			if (bad)
				$display("Data client finished after the instruction client in %0s", t_name[1]);
			check_slot(1, 1'b0, bad);
		end
		else if (paired)
		begin
			bad = 1'b0;
			for (n = 0; n < 8; n++)
			begin
				@(negedge clk);
				bad = bad || data_busy || inst_busy;
			end
			if (bad)
				$display("Request %0s given while busy started a transfer", t_name[1]);
			end_test(1, bad);
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		inst_req = 1'b0;
		inst_addr = '0;
		data_req = 1'b0;
		data_rd_not_wr = 1'b1;
		data_addr = '0;
		data_wdata = '0;
		rng = 32'd15956;
		fd = $fopen("testbench/mem_bus_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open testbench/mem_bus_testdata.txt");
			n_fail++;
			stop = 1'b1;
		end
		else
			repeat (2)
				line_ok = ($fgets(header, fd) > 0); // Column description
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		while (!stop)
		begin
			read_line(0, line_ok);
			if (line_ok)
				run_group();
			else
				stop = 1'b1;
		end
		if (u_mem_bus_system.u_arbiter.u_mem_bus_chk.n_errors > 0)
		begin
			$display("Bus assertions failed %0d times",
				u_mem_bus_system.u_arbiter.u_mem_bus_chk.n_errors);
			n_fail = n_fail + u_mem_bus_system.u_arbiter.u_mem_bus_chk.n_errors;
		end
		$display("Tests finished: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0 && n_pass > 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire
